//--- src/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Data path width in bits
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32

// Bits needed to index one register
`define RV_REG_W 5

`endif

//--- src/rv_core_pkg.sv
`include "rv_core_settings.svh"

package rv_core_pkg;

    // Major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // Register-register format
    typedef struct packed {
        logic [6:0]           funct7;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } rv_r_type_t;

    // Register-immediate format
    typedef struct packed {
        logic [11:0]          imm12;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } rv_i_type_t;

    // Upper immediate format
    typedef struct packed {
        logic [19:0]          imm20;
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } rv_u_type_t;

    // One instruction word seen through each format
    typedef union packed {
        rv_r_type_t r;
        rv_i_type_t i;
        rv_u_type_t u;
    } rv_instr_u;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_LUI  = 4'd10   // Second operand passed straight through
    } rv_alu_op_e;

endpackage

//--- src/rv_decode.sv
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_decode (
    input  logic                    sys_clk,
    input  logic                    sys_rst,
    input  logic [`RV_XLEN-1:0]     instr_i,
    input  logic                    instr_valid_i,
    output logic                    dec_valid_o,
    output logic                    dec_illegal_o,
    output rv_core_pkg::rv_alu_op_e dec_alu_op_o,
    output logic                    dec_use_imm_o,
    output logic [`RV_XLEN-1:0]     dec_imm_o,
    output logic [`RV_REG_W-1:0]    dec_rd_o,
    output logic [`RV_REG_W-1:0]    dec_rs1_o,
    output logic [`RV_REG_W-1:0]    dec_rs2_o
);

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

    rv_core_pkg::rv_instr_u  instr;
    rv_core_pkg::rv_alu_op_e alu_op;
    logic                    illegal;
    logic                    use_imm;
    logic [`RV_XLEN-1:0]     imm;
    logic [`RV_REG_W-1:0]    rs1;
    logic [`RV_REG_W-1:0]    rs2;

    assign instr = instr_i;

    always_comb begin
        alu_op  = rv_core_pkg::ALU_ADD;
        illegal = 1'b0;
        use_imm = 1'b0;
        imm     = '0;
        rs1     = '0;  // Unused operands read x0
        rs2     = '0;
        case (instr.r.opcode)
            rv_core_pkg::OPC_OP: begin
                rs1 = instr.r.rs1;
                rs2 = instr.r.rs2;
                case (instr.r.funct3)
                    F3_ADD:  alu_op = (instr.r.funct7 == F7_ALT) ? rv_core_pkg::ALU_SUB
                                                                 : rv_core_pkg::ALU_ADD;
                    F3_SLL:  alu_op = rv_core_pkg::ALU_SLL;
                    F3_SLT:  alu_op = rv_core_pkg::ALU_SLT;
                    F3_SLTU: alu_op = rv_core_pkg::ALU_SLTU;
                    F3_XOR:  alu_op = rv_core_pkg::ALU_XOR;
                    F3_SR:   alu_op = (instr.r.funct7 == F7_ALT) ? rv_core_pkg::ALU_SRA
                                                                 : rv_core_pkg::ALU_SRL;
                    F3_OR:   alu_op = rv_core_pkg::ALU_OR;
                    F3_AND:  alu_op = rv_core_pkg::ALU_AND;
                endcase
                // Alternate funct7 only valid for SUB and SRA
                if (instr.r.funct7 == F7_ALT) begin
                    illegal = (instr.r.funct3 != F3_ADD) && (instr.r.funct3 != F3_SR);
                end else if (instr.r.funct7 != F7_BASE) begin
                    illegal = 1'b1;
                end
            end
            rv_core_pkg::OPC_OP_IMM: begin
                rs1     = instr.i.rs1;
                use_imm = 1'b1;
                imm     = {{(`RV_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
                case (instr.i.funct3)
                    F3_ADD:  alu_op = rv_core_pkg::ALU_ADD;
                    F3_SLT:  alu_op = rv_core_pkg::ALU_SLT;
                    F3_SLTU: alu_op = rv_core_pkg::ALU_SLTU;
                    F3_XOR:  alu_op = rv_core_pkg::ALU_XOR;
                    F3_OR:   alu_op = rv_core_pkg::ALU_OR;
                    F3_AND:  alu_op = rv_core_pkg::ALU_AND;
                    F3_SLL: begin
                        alu_op  = rv_core_pkg::ALU_SLL;
                        illegal = (instr.i.imm12[11:5] != F7_BASE);
                    end
                    F3_SR: begin
                        // Upper immediate bits pick logical or arithmetic
                        alu_op  = (instr.i.imm12[11:5] == F7_ALT) ? rv_core_pkg::ALU_SRA
                                                                  : rv_core_pkg::ALU_SRL;
                        illegal = (instr.i.imm12[11:5] != F7_BASE) &&
                                  (instr.i.imm12[11:5] != F7_ALT);
                    end
                endcase
            end
            rv_core_pkg::OPC_LUI: begin
                alu_op  = rv_core_pkg::ALU_LUI;
                use_imm = 1'b1;
                imm     = {instr.u.imm20, {(`RV_XLEN-20){1'b0}}};
            end
            default: illegal = 1'b1;  // Anything outside the subset
        endcase
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            dec_valid_o   <= 1'b0;
            dec_illegal_o <= 1'b0;
        end else begin
            dec_valid_o   <= instr_valid_i;
            dec_illegal_o <= instr_valid_i && illegal;
        end
    end

    // Decoded fields, qualified by dec_valid_o
    always_ff @(posedge sys_clk) begin
        dec_alu_op_o  <= alu_op;
        dec_use_imm_o <= use_imm;
        dec_imm_o     <= imm;
        dec_rd_o      <= instr.r.rd;
        dec_rs1_o     <= rs1;
        dec_rs2_o     <= rs2;
    end

endmodule

//--- src/rv_execute.sv
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_execute (
    input  logic                    sys_clk,
    input  logic                    sys_rst,
    input  logic                    dec_valid_i,
    input  logic                    dec_illegal_i,
    input  rv_core_pkg::rv_alu_op_e dec_alu_op_i,
    input  logic                    dec_use_imm_i,
    input  logic [`RV_XLEN-1:0]     dec_imm_i,
    input  logic [`RV_REG_W-1:0]    dec_rd_i,
    input  logic [`RV_XLEN-1:0]     rs1_data_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    output logic                    ex_valid_o,
    output logic                    ex_illegal_o,
    output logic [`RV_REG_W-1:0]    ex_rd_o,
    output logic [`RV_XLEN-1:0]     ex_data_o
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] result;
    logic [SHAMT_W-1:0]  shamt;

    assign op_a  = rs1_data_i;
    assign op_b  = dec_use_imm_i ? dec_imm_i : rs2_data_i;
    assign shamt = op_b[SHAMT_W-1:0];  // Only the low bits count for shifts

    always_comb begin
        case (dec_alu_op_i)
            rv_core_pkg::ALU_ADD:  result = op_a + op_b;
            rv_core_pkg::ALU_SUB:  result = op_a - op_b;  // Wraps on underflow
            rv_core_pkg::ALU_AND:  result = op_a & op_b;
            rv_core_pkg::ALU_OR:   result = op_a | op_b;
            rv_core_pkg::ALU_XOR:  result = op_a ^ op_b;
            rv_core_pkg::ALU_SLT: begin
                result = {{(`RV_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            rv_core_pkg::ALU_SLTU: begin
                result = {{(`RV_XLEN-1){1'b0}}, (op_a < op_b)};
            end
            rv_core_pkg::ALU_SLL:  result = op_a << shamt;
            rv_core_pkg::ALU_SRL:  result = op_a >> shamt;
            rv_core_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            rv_core_pkg::ALU_LUI:  result = op_b;  // Immediate already shifted by decode
            default:               result = '0;
        endcase
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            ex_valid_o   <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else begin
            ex_valid_o   <= dec_valid_i;
            ex_illegal_o <= dec_valid_i && dec_illegal_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        ex_rd_o   <= dec_rd_i;
        ex_data_o <= dec_illegal_i ? '0 : result;  // Illegal words report zero
    end

endmodule

//--- src/rv_result.sv
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_result (
    input  logic                 sys_clk,
    input  logic                 sys_rst,
    input  logic                 ex_valid_i,
    input  logic                 ex_illegal_i,
    input  logic [`RV_REG_W-1:0] ex_rd_i,
    input  logic [`RV_XLEN-1:0]  ex_data_i,
    input  logic [`RV_REG_W-1:0] rs1_addr_i,
    input  logic [`RV_REG_W-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]  rs1_data_o,
    output logic [`RV_XLEN-1:0]  rs2_data_o,
    output logic                 wb_valid_o,
    output logic [`RV_REG_W-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]  wb_data_o,
    output logic                 wb_illegal_o
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];
    logic                wr_en;

    assign wr_en = ex_valid_i && !ex_illegal_i && (ex_rd_i != '0);

    // Stored value, or the result about to be written
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_W-1:0] addr);
        logic [`RV_XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (ex_rd_i == addr)) begin
            data = ex_data_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;  // Architectural state starts at zero
            end
        end else if (wr_en) begin
            regs[ex_rd_i] <= ex_data_i;
        end
    end

    // Write-back report straight from the execute registers
    assign wb_valid_o   = ex_valid_i;
    assign wb_rd_o      = ex_rd_i;
    assign wb_data_o    = ex_data_i;
    assign wb_illegal_o = ex_illegal_i;

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_core_top (
    input  logic                 sys_clk,
    input  logic                 sys_rst,
    input  logic [`RV_XLEN-1:0]  instr_i,
    input  logic                 instr_valid_i,
    output logic                 wb_valid_o,
    output logic [`RV_REG_W-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]  wb_data_o,
    output logic                 wb_illegal_o
);

    // Decode to execute
    logic                    dec_valid;
    logic                    dec_illegal;
    rv_core_pkg::rv_alu_op_e dec_alu_op;
    logic                    dec_use_imm;
    logic [`RV_XLEN-1:0]     dec_imm;
    logic [`RV_REG_W-1:0]    dec_rd;
    logic [`RV_REG_W-1:0]    dec_rs1;  // Also the register file read addresses
    logic [`RV_REG_W-1:0]    dec_rs2;

    // Register file read data, bypassed
    logic [`RV_XLEN-1:0]     rs1_data;
    logic [`RV_XLEN-1:0]     rs2_data;

    // Execute to result
    logic                    ex_valid;
    logic                    ex_illegal;
    logic [`RV_REG_W-1:0]    ex_rd;
    logic [`RV_XLEN-1:0]     ex_data;

    rv_decode u_decode (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .dec_valid_o   (dec_valid),
        .dec_illegal_o (dec_illegal),
        .dec_alu_op_o  (dec_alu_op),
        .dec_use_imm_o (dec_use_imm),
        .dec_imm_o     (dec_imm),
        .dec_rd_o      (dec_rd),
        .dec_rs1_o     (dec_rs1),
        .dec_rs2_o     (dec_rs2)
    );

    rv_execute u_execute (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .dec_valid_i   (dec_valid),
        .dec_illegal_i (dec_illegal),
        .dec_alu_op_i  (dec_alu_op),
        .dec_use_imm_i (dec_use_imm),
        .dec_imm_i     (dec_imm),
        .dec_rd_i      (dec_rd),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_valid_o    (ex_valid),
        .ex_illegal_o  (ex_illegal),
        .ex_rd_o       (ex_rd),
        .ex_data_o     (ex_data)
    );

    rv_result u_result (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .ex_valid_i   (ex_valid),
        .ex_illegal_i (ex_illegal),
        .ex_rd_i      (ex_rd),
        .ex_data_i    (ex_data),
        .rs1_addr_i   (dec_rs1),
        .rs2_addr_i   (dec_rs2),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .wb_illegal_o (wb_illegal_o)
    );

endmodule

//--- dv/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module tb_rv_core;

    localparam int    CLK_PERIOD  = 100;
    localparam int    MAX_ENTRIES = 64;
    localparam string GOLDEN_PATH = "dv/rv_core_golden.txt";

    logic                 sys_clk;
    logic                 sys_rst;
    logic [`RV_XLEN-1:0]  instr_i;
    logic                 instr_valid_i;
    logic                 wb_valid_o;
    logic [`RV_REG_W-1:0] wb_rd_o;
    logic [`RV_XLEN-1:0]  wb_data_o;
    logic                 wb_illegal_o;

    // Golden entries, one per instruction
    logic [`RV_XLEN-1:0]  g_instr   [0:MAX_ENTRIES-1];
    logic [`RV_REG_W-1:0] g_rd      [0:MAX_ENTRIES-1];
    logic [`RV_XLEN-1:0]  g_data    [0:MAX_ENTRIES-1];
    logic                 g_illegal [0:MAX_ENTRIES-1];

    int n_entries  = 0;
    int n_sent     = 0;
    int n_checked  = 0;
    int n_mismatch = 0;
    int n_other    = 0;
    int seed       = 83136;
    bit loaded     = 1'b0;

    rv_core_top i_dut (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_illegal_o  (wb_illegal_o)
    );

    always #(CLK_PERIOD/2) sys_clk = ~sys_clk;

    // Four hex columns per data line, comment lines skipped
    task automatic load_golden();
        int                   fd;
        int                   cnt;
        string                line;
        logic [`RV_XLEN-1:0]  word;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  data;
        logic                 illegal;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            n_other++;
            $display("could not open the golden file %s", GOLDEN_PATH);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "/" && line[0] != "\n") begin
                    cnt = $sscanf(line, "%h %h %h %h", word, rd, data, illegal);
                    if (cnt != 4) begin
                        n_other++;
                        $display("golden line could not be parsed: %s", line);
                    end else if (n_entries >= MAX_ENTRIES) begin
                        n_other++;
                        $display("golden file holds more entries than the testbench can store");
                    end else begin
                        g_instr[n_entries]   = word;
                        g_rd[n_entries]      = rd;
                        g_data[n_entries]    = data;
                        g_illegal[n_entries] = illegal;
                        n_entries++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One instruction on the next falling edge
    task automatic send_instr(input int idx);
        @(negedge sys_clk);
        instr_i       = g_instr[idx];
        instr_valid_i = 1'b1;
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            instr_valid_i = 1'b0;
            instr_i       = '0;
        end
    endtask

    // Instructions the DUT has actually sampled
    always @(posedge sys_clk) begin
        if (!sys_rst && instr_valid_i) begin
            n_sent++;
        end
    end

    // Outputs come from registers, so the falling edge sees settled values
    always @(negedge sys_clk) begin
        if (!sys_rst && wb_valid_o) begin
            assert (n_checked < n_sent) else begin
                n_other++;
                $display("write-back seen before its instruction was sent");
            end
            if (n_checked >= n_entries) begin
                n_other++;
                $display("write-back seen with no golden entry left");
            end else begin
                assert (wb_rd_o == g_rd[n_checked]) else begin
                    n_mismatch++;
                    $display("mismatch wb_rd_o entry %0d: expected %h, actual %h",
                             n_checked, g_rd[n_checked], wb_rd_o);
                end
                assert (wb_data_o == g_data[n_checked]) else begin
                    n_mismatch++;
                    $display("mismatch wb_data_o entry %0d: expected %h, actual %h",
                             n_checked, g_data[n_checked], wb_data_o);
                end
                assert (wb_illegal_o == g_illegal[n_checked]) else begin
                    n_mismatch++;
                    $display("mismatch wb_illegal_o entry %0d: expected %h, actual %h",
                             n_checked, g_illegal[n_checked], wb_illegal_o);
                end
                n_checked++;
            end
        end
    end

    // Up to three cycles per entry, plus reset and pipeline drain
    initial begin
        wait (loaded);
        #((n_entries * 3 + 20) * CLK_PERIOD);
        $display("timeout: only %0d of %0d write-backs arrived", n_checked, n_entries);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int gap;
        sys_clk       = 1'b0;
        sys_rst       = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (4) @(negedge sys_clk);
        sys_rst = 1'b0;
        idle_cycles(2);  // Quiet pipeline after reset
        for (int i = 0; i < n_entries; i++) begin
            send_instr(i);
            gap = $unsigned($random(seed)) % 3;
            idle_cycles(gap);
        end
        idle_cycles(1);
        wait (n_checked == n_entries);
        idle_cycles(4);  // Catch any extra pulse
        $display("Checked %0d of %0d write-backs, %0d mismatches, %0d other errors",
                 n_checked, n_entries, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- dv/rv_core_golden.txt
// Columns: instruction word, expected rd, expected data, expected illegal flag (all hex)
// Entries are checked in order, one write-back each
// Immediate forms and LUI
00510093 01 00000005 0 // addi x1, x2, 5 with x2 still zero
ffd00113 02 fffffffd 0 // addi x2, x0, -3
40115193 03 fffffffe 0 // srai x3, x2, 1
00415213 04 0fffffff 0 // srli x4, x2, 4
00309293 05 00000028 0 // slli x5, x1, 3
0f017313 06 000000f0 0 // andi x6, x2, 0xf0
f000e393 07 ffffff05 0 // ori x7, x1, -256
fff3c413 08 000000fa 0 // xori x8, x7, -1
00512493 09 00000001 0 // slti x9, x2, 5
00513513 0a 00000000 0 // sltiu x10, x2, 5
123455b7 0b 12345000 0 // lui x11, 0x12345
fffff637 0c fffff000 0 // lui x12, 0xfffff
// Register forms
001586b3 0d 12345005 0 // add x13, x11, x1
40b08733 0e edcbb005 0 // sub x14, x1, x11
401007b3 0f fffffffb 0 // sub x15, x0, x1
00c77833 10 edcbb000 0 // and x16, x14, x12
00b468b3 11 123450fa 0 // or x17, x8, x11
00d8c933 12 000000ff 0 // xor x18, x17, x13
0017a9b3 13 00000001 0 // slt x19, x15, x1
0017ba33 14 00000000 0 // sltu x20, x15, x1
00509ab3 15 00000500 0 // sll x21, x1, x5
0017db33 16 07ffffff 0 // srl x22, x15, x1
40175bb3 17 ff6e5d80 0 // sra x23, x14, x1
// Dependent chain
06400c13 18 00000064 0 // addi x24, x0, 100
018c0c33 18 000000c8 0 // add x24, x24, x24
fffc0c13 18 000000c7 0 // addi x24, x24, -1
004c1c93 19 00000c70 0 // slli x25, x24, 4
418c8d33 1a 00000ba9 0 // sub x26, x25, x24
019d4d33 1a 000007d9 0 // xor x26, x26, x25
// x0 writes report data but store nothing
00708013 00 0000000c 0 // addi x0, x1, 7
00100db3 1b 00000005 0 // add x27, x0, x1
// Illegal words leave registers alone
021080b3 01 00000000 1 // mul x1, x1, x1
00008e13 1c 00000005 0 // addi x28, x1, 0
00002103 02 00000000 1 // lw x2, 0(x0)
40111193 03 00000000 1 // slli x3 with bad upper bits
00316eb3 1d ffffffff 0 // or x29, x2, x3
01cd8f33 1e 0000000a 0 // add x30, x27, x28

//--- build.f
+incdir+src
src/rv_core_pkg.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_top.sv
dv/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_core_pkg.sv
      - src/rv_decode.sv
      - src/rv_execute.sv
      - src/rv_result.sv
      - src/rv_core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_rv_core.sv
